/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lc4_core
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
+incdir+sim
src/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_hazard_unit.sv
src/lc4_regfile.sv
src/lc4_fetch.sv
src/lc4_execute.sv
src/lc4_mem_stage.sv
src/lc4_core.sv
sim/tb_lc4_core.sv

/* sim/tb_lc4_program.svh */
localparam int PROG_LEN = 24;

// program image, first word sits at RESET_PC
localparam word_t PROG [PROG_LEN] = '{
    16'h9005, // const r0, #5
    16'h93fd, // const r1, #-3
    16'h9420, // const r2, #0x20, data base
    16'h96f0, // const r3, #0xf0
    16'h1801, // add r4, r0, r1
    16'h1ad0, // sub r5, r3, r0
    16'h5d05, // and r6, r4, r5
    16'h5f5b, // xor r7, r5, r3
    16'h5997, // or  r4, r6, r7
    16'h1b7f, // add r5, r5, #-1
    16'h7881, // str r4, r2, #1
    16'h6c83, // ldr r6, r2, #3   paired with a store, split
    16'h1f80, // add r7, r6, r0   reads the load of its own pair
    16'h6281, // ldr r1, r2, #1
    16'h1641, // add r3, r1, r1   load-use in pipe a
    16'h7ebe, // str r7, r2, #-2
    16'h9100, // const r0, #-256
    16'h7084, // str r0, r2, #4   store data from pipe a of the same pair
    16'h6abe, // ldr r5, r2, #-2
    16'h5d5b, // xor r6, r5, r3
    16'h6885, // ldr r4, r2, #5
    16'h12a2, // add r1, r2, #2
    16'h1e14, // sub r7, r0, r4   load-use in pipe b
    16'h7e86  // str r7, r2, #6
};

// index, kind, wsel, wdata or store data, dmem address
task automatic build_expected();
    set_exp(0,  K_WR, 3'd0, 16'h0005, 16'h0000);
    set_exp(1,  K_WR, 3'd1, 16'hfffd, 16'h0000);
    set_exp(2,  K_WR, 3'd2, 16'h0020, 16'h0000);
    set_exp(3,  K_WR, 3'd3, 16'h00f0, 16'h0000);
    set_exp(4,  K_WR, 3'd4, 16'h0002, 16'h0000);
    set_exp(5,  K_WR, 3'd5, 16'h00eb, 16'h0000);
    set_exp(6,  K_WR, 3'd6, 16'h0002, 16'h0000);
    set_exp(7,  K_WR, 3'd7, 16'h001b, 16'h0000);
    set_exp(8,  K_WR, 3'd4, 16'h001b, 16'h0000);
    set_exp(9,  K_WR, 3'd5, 16'h00ea, 16'h0000);
    set_exp(10, K_ST, 3'd0, 16'h001b, 16'h0021);
    set_exp(11, K_LD, 3'd6, d0[35], 16'h0023);
    set_exp(12, K_WR, 3'd7, d0[35] + 16'd5, 16'h0000);
    set_exp(13, K_LD, 3'd1, 16'h001b, 16'h0021); // written by the first store
    set_exp(14, K_WR, 3'd3, 16'h0036, 16'h0000);
    set_exp(15, K_ST, 3'd0, d0[35] + 16'd5, 16'h001e);
    set_exp(16, K_WR, 3'd0, 16'hff00, 16'h0000);
    set_exp(17, K_ST, 3'd0, 16'hff00, 16'h0024);
    set_exp(18, K_LD, 3'd5, d0[35] + 16'd5, 16'h001e);
    set_exp(19, K_WR, 3'd6, (d0[35] + 16'd5) ^ 16'h0036, 16'h0000);
    set_exp(20, K_LD, 3'd4, d0[37], 16'h0025);
    set_exp(21, K_WR, 3'd1, 16'h0022, 16'h0000);
    set_exp(22, K_WR, 3'd7, 16'hff00 - d0[37], 16'h0000);
    set_exp(23, K_ST, 3'd0, 16'hff00 - d0[37], 16'h0026);
endtask

/* sim/tb_lc4_core.sv */
`timescale 1ns/1ps

module tb_lc4_core import lc4_pkg::*; ();

    localparam logic [31:0] SEED = 32'h16f05db6;
    localparam logic [1:0] K_WR = 2'd0; // register write only
    localparam logic [1:0] K_LD = 2'd1;
    localparam logic [1:0] K_ST = 2'd2;

    logic    gwe;
    logic    arst_n;
    word_t   pc;
    word_t   insn_a;
    word_t   insn_b;
    word_t   dmem_addr;
    logic    dmem_we;
    word_t   dmem_wdata;
    word_t   dmem_rdata;
    retire_t retire_a;
    retire_t retire_b;

    word_t d0 [64]; // random image, reloaded into dmem during reset
    word_t dmem [64];

    `include "tb_lc4_program.svh"

    localparam int MAX_CYCLES = 2 * PROG_LEN + 20;

    logic [1:0] exp_kind [PROG_LEN];
    reg_idx_t   exp_wsel [PROG_LEN];
    word_t      exp_val  [PROG_LEN];
    word_t      exp_addr [PROG_LEN];

    int idx          = 0; // next expected retire
    int st_ptr       = 0;
    int cycles       = 0;
    int first_mem    = PROG_LEN; // first load or store in program order
    int alu_bubbles  = 0;
    int stall_cycles = 0;
    int checks       = 0;
    int errors       = 0;

    lc4_core lc4_core_i (
        .gwe(gwe), .i_arst_n(arst_n), .o_pc(pc), .i_insn_a(insn_a), .i_insn_b(insn_b),
        .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
        .i_dmem_rdata(dmem_rdata), .o_retire_a(retire_a), .o_retire_b(retire_b)
    );

    initial begin
        gwe = 1'b0;
        forever #20 gwe = ~gwe;
    end

    function automatic word_t imem_read(input word_t addr);
        int off;
        off = int'(addr) - int'(RESET_PC);
        if (off >= 0 && off < PROG_LEN) return PROG[off];
        return 16'h0000; // nop past the end
    endfunction

    assign insn_a     = imem_read(pc);
    assign insn_b     = imem_read(pc + 16'd1);
    assign dmem_rdata = dmem[dmem_addr[5:0]];

    always @(posedge gwe) begin
        if (!arst_n) begin
            dmem <= d0;
        end else if (dmem_we) begin
            dmem[dmem_addr[5:0]] <= dmem_wdata;
        end
    end

    task automatic set_exp(input int n, input logic [1:0] kind, input reg_idx_t wsel,
                           input word_t val, input word_t addr);
        exp_kind[n] = kind;
        exp_wsel[n] = wsel;
        exp_val[n]  = val;
        exp_addr[n] = addr;
    endtask

    task automatic expect_eq(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // one trace slot against the next program-order entry
    task automatic check_slot(input retire_t r, input string pipe);
        logic [1:0] k;
        if (!r.valid) begin
            if (idx > 0 && idx <= first_mem) alu_bubbles++; // alu pairs never stall
            return;
        end
        if (idx >= PROG_LEN) return; // nops past the program
        k = exp_kind[idx];
        expect_eq({pipe, ".pc"}, r.pc, RESET_PC + 16'(idx));
        expect_eq({pipe, ".insn"}, r.insn, PROG[idx]);
        expect_eq({pipe, ".rf_we"}, 16'(r.rf_we), (k == K_ST) ? 16'd0 : 16'd1);
        expect_eq({pipe, ".dmem_we"}, 16'(r.dmem_we), (k == K_ST) ? 16'd1 : 16'd0);
        if (k != K_ST) begin
            expect_eq({pipe, ".wsel"}, 16'(r.wsel), 16'(exp_wsel[idx]));
            expect_eq({pipe, ".wdata"}, r.wdata, exp_val[idx]);
        end
        if (k != K_WR) begin
            expect_eq({pipe, ".dmem_addr"}, r.dmem_addr, exp_addr[idx]);
            expect_eq({pipe, ".dmem_data"}, r.dmem_data, exp_val[idx]);
        end
        idx++;
    endtask

    // stores on the port must follow the program's store order
    task automatic check_store();
        if (!dmem_we) return;
        while (st_ptr < PROG_LEN && exp_kind[st_ptr] != K_ST) st_ptr++;
        checks++;
        assert (st_ptr < PROG_LEN) else begin
            errors++;
            $display("store to dmem address %h with no store left in the program", dmem_addr);
        end
        if (st_ptr < PROG_LEN) begin
            expect_eq("o_dmem_addr", dmem_addr, exp_addr[st_ptr]);
            expect_eq("o_dmem_wdata", dmem_wdata, exp_val[st_ptr]);
            st_ptr++;
        end
    endtask

    initial begin
        arst_n = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < 64; i++) begin
            d0[i] = 16'($urandom);
        end
        build_expected();
        for (int i = PROG_LEN - 1; i >= 0; i--) begin
            if (exp_kind[i] != K_WR) first_mem = i;
        end

        repeat (4) @(posedge gwe);
        #2 arst_n = 1'b1;
        @(negedge gwe); // still in the reset state
        expect_eq("o_pc", pc, RESET_PC);
        expect_eq("o_retire_a.valid", 16'(retire_a.valid), 16'd0);
        expect_eq("o_retire_b.valid", 16'(retire_b.valid), 16'd0);
        expect_eq("o_dmem_we", 16'(dmem_we), 16'd0);

        while (idx < PROG_LEN && cycles < MAX_CYCLES) begin
            @(negedge gwe);
            cycles++;
            if (!retire_a.valid && !retire_b.valid && idx > 0 && idx < PROG_LEN) begin
                stall_cycles++; // whole pair held back
            end
            check_store();
            check_slot(retire_a, "o_retire_a");
            check_slot(retire_b, "o_retire_b");
        end

        checks++;
        assert (idx == PROG_LEN) else begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, idx, PROG_LEN);
        end
        while (st_ptr < PROG_LEN && exp_kind[st_ptr] != K_ST) st_ptr++;
        checks++;
        assert (st_ptr == PROG_LEN) else begin
            errors++;
            $display("a store of the program never appeared on the dmem port");
        end
        checks++;
        assert (alu_bubbles == 0) else begin
            errors++;
            $display("the ALU pairs ahead of the first memory instruction stalled or split");
        end
        checks++;
        assert (stall_cycles > 0) else begin
            errors++;
            $display("no cycle with both trace slots empty appeared across the load-use stalls");
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src/lc4_core.sv */
`timescale 1ns/1ps

module lc4_core import lc4_pkg::*; (
    input  logic    gwe,
    input  logic    i_arst_n,
    output word_t   o_pc,
    input  insn_u   i_insn_a,
    input  insn_u   i_insn_b,
    output word_t   o_dmem_addr,
    output logic    o_dmem_we,
    output word_t   o_dmem_wdata,
    input  word_t   i_dmem_rdata,
    output retire_t o_retire_a,
    output retire_t o_retire_b
);

    logic  hold;
    logic  swap;
    logic  kill_a;
    logic  kill_b;
    slot_t d_slot_a; // fetch/decode register
    slot_t d_slot_b;
    ctrl_t ctrl_a;
    ctrl_t ctrl_b;
    word_t rs_data_a;
    word_t rt_data_a;
    word_t rs_data_b;
    word_t rt_data_b;
    slot_t dec_a;
    slot_t dec_b;
    slot_t x_slot_a; // decode/execute register
    slot_t x_slot_b;
    slot_t x_out_a;
    slot_t x_out_b;
    slot_t m_slot_a; // execute/memory register
    slot_t m_slot_b;
    fwd_t  m_fwd_a;
    fwd_t  m_fwd_b;
    fwd_t  w_fwd_a;
    fwd_t  w_fwd_b;

    lc4_fetch fetch_i (
        .gwe(gwe), .i_arst_n(i_arst_n), .i_hold(hold), .i_swap(swap),
        .i_insn_a(i_insn_a), .i_insn_b(i_insn_b), .o_pc(o_pc),
        .o_d_slot_a(d_slot_a), .o_d_slot_b(d_slot_b)
    );

    lc4_decoder dec_a_i (.i_insn(d_slot_a.insn), .o_ctrl(ctrl_a));
    lc4_decoder dec_b_i (.i_insn(d_slot_b.insn), .o_ctrl(ctrl_b));

    lc4_hazard_unit hazard_i (
        .i_ctrl_a(ctrl_a), .i_ctrl_b(ctrl_b), .i_x_slot_a(x_slot_a), .i_x_slot_b(x_slot_b),
        .o_hold(hold), .o_swap(swap), .o_kill_a(kill_a), .o_kill_b(kill_b)
    );

    lc4_regfile regfile_i (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs_a(ctrl_a.r1), .i_rt_a(ctrl_a.r2), .i_rs_b(ctrl_b.r1), .i_rt_b(ctrl_b.r2),
        .i_wr_a(w_fwd_a), .i_wr_b(w_fwd_b),
        .o_rs_data_a(rs_data_a), .o_rt_data_a(rt_data_a),
        .o_rs_data_b(rs_data_b), .o_rt_data_b(rt_data_b)
    );

    // killed slot becomes an invalid nop bubble
    function automatic slot_t fill_slot(input slot_t s, input ctrl_t c, input word_t r1,
                                        input word_t r2, input logic kill);
        slot_t f;
        if (kill) return '0;
        f         = s;
        f.ctrl    = c;
        f.r1_data = r1;
        f.r2_data = r2;
        return f;
    endfunction

    assign dec_a = fill_slot(d_slot_a, ctrl_a, rs_data_a, rt_data_a, kill_a);
    assign dec_b = fill_slot(d_slot_b, ctrl_b, rs_data_b, rt_data_b, kill_b);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_slot_a <= '0;
            x_slot_b <= '0;
            m_slot_a <= '0;
            m_slot_b <= '0;
        end else begin
            x_slot_a <= dec_a;
            x_slot_b <= dec_b;
            m_slot_a <= x_out_a;
            m_slot_b <= x_out_b;
        end
    end

    lc4_execute exec_a_i (
        .i_slot(x_slot_a), .i_m_a(m_fwd_a), .i_m_b(m_fwd_b),
        .i_w_a(w_fwd_a), .i_w_b(w_fwd_b), .o_slot(x_out_a)
    );

    lc4_execute exec_b_i (
        .i_slot(x_slot_b), .i_m_a(m_fwd_a), .i_m_b(m_fwd_b),
        .i_w_a(w_fwd_a), .i_w_b(w_fwd_b), .o_slot(x_out_b)
    );

    // a load here still holds its address, not its data
    assign m_fwd_a = '{we: m_slot_a.valid && m_slot_a.ctrl.rf_we && !m_slot_a.ctrl.is_load,
                       rd: m_slot_a.ctrl.rd, value: m_slot_a.result};
    assign m_fwd_b = '{we: m_slot_b.valid && m_slot_b.ctrl.rf_we && !m_slot_b.ctrl.is_load,
                       rd: m_slot_b.ctrl.rd, value: m_slot_b.result};

    lc4_mem_stage mem_i (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_m_slot_a(m_slot_a), .i_m_slot_b(m_slot_b), .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata), .o_dmem_we(o_dmem_we),
        .o_w_a(w_fwd_a), .o_w_b(w_fwd_b), .o_retire_a(o_retire_a), .o_retire_b(o_retire_b)
    );

    // both trace slots valid means both came from one fetched pair
    a_pair_order: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_retire_a.valid && o_retire_b.valid |-> o_retire_b.pc == o_retire_a.pc + 16'd1);

endmodule

/* src/lc4_decoder.sv */
`timescale 1ns/1ps

module lc4_decoder import lc4_pkg::*; (
    input  insn_u i_insn,
    output ctrl_t o_ctrl
);

    always_comb begin
        o_ctrl    = '0; // nop unless matched below
        o_ctrl.r1 = i_insn.rv.rs;
        o_ctrl.r2 = i_insn.rv.rt;
        o_ctrl.rd = i_insn.rv.rd;
        case (i_insn.rv.opcode)
            OP_ARITH: begin
                if (i_insn.rv.imm_flag) begin
                    // imm5 sits in the sub_op and rt bits
                    o_ctrl.imm     = {{11{i_insn.rv.sub_op[1]}}, i_insn.rv.sub_op, i_insn.rv.rt};
                    o_ctrl.imm_sel = 1'b1;
                    o_ctrl.rf_we   = 1'b1;
                end else if (i_insn.rv.sub_op == SUB_ADD || i_insn.rv.sub_op == SUB_SUB) begin
                    o_ctrl.alu_op = (i_insn.rv.sub_op == SUB_SUB) ? ALU_SUB : ALU_ADD;
                    o_ctrl.rf_we  = 1'b1;
                    o_ctrl.r2_re  = 1'b1;
                end
                o_ctrl.r1_re = o_ctrl.rf_we; // mul and div fall out as nop
            end
            OP_LOGIC: begin
                if (!i_insn.rv.imm_flag) begin
                    o_ctrl.rf_we = 1'b1;
                    case (i_insn.rv.sub_op)
                        SUB_AND: o_ctrl.alu_op = ALU_AND;
                        SUB_OR:  o_ctrl.alu_op = ALU_OR;
                        SUB_XOR: o_ctrl.alu_op = ALU_XOR;
                        default: o_ctrl.rf_we  = 1'b0; // not
                    endcase
                end
                o_ctrl.r1_re = o_ctrl.rf_we;
                o_ctrl.r2_re = o_ctrl.rf_we;
            end
            OP_LDR, OP_STR: begin
                o_ctrl.r1       = i_insn.ov.rs;
                o_ctrl.r1_re    = 1'b1;
                o_ctrl.imm      = {{10{i_insn.ov.offset6[5]}}, i_insn.ov.offset6};
                o_ctrl.imm_sel  = 1'b1; // base + offset
                o_ctrl.is_load  = (i_insn.ov.opcode == OP_LDR);
                o_ctrl.is_store = (i_insn.ov.opcode == OP_STR);
                o_ctrl.rf_we    = o_ctrl.is_load;
                o_ctrl.rd       = i_insn.ov.rd_rt;
                o_ctrl.r2       = i_insn.ov.rd_rt;
                o_ctrl.r2_re    = o_ctrl.is_store;
            end
            OP_CONST: begin
                o_ctrl.rd      = i_insn.cv.rd;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.imm     = {{7{i_insn.cv.imm9[8]}}, i_insn.cv.imm9};
                o_ctrl.imm_sel = 1'b1;
                o_ctrl.alu_op  = ALU_PASS;
            end
            default: ;
        endcase
    end

endmodule

/* src/lc4_execute.sv */
`timescale 1ns/1ps

module lc4_execute import lc4_pkg::*; (
    input  slot_t i_slot,
    input  fwd_t  i_m_a,
    input  fwd_t  i_m_b,
    input  fwd_t  i_w_a,
    input  fwd_t  i_w_b,
    output slot_t o_slot
);

    word_t op_a;
    word_t op_b;
    word_t rt_val;

    // newest producer wins, b is younger than a within a stage
    function automatic word_t bypass(input reg_idx_t idx, input word_t rf_val);
        if (i_m_b.we && i_m_b.rd == idx) return i_m_b.value;
        if (i_m_a.we && i_m_a.rd == idx) return i_m_a.value;
        if (i_w_b.we && i_w_b.rd == idx) return i_w_b.value;
        if (i_w_a.we && i_w_a.rd == idx) return i_w_a.value;
        return rf_val;
    endfunction

    always_comb begin
        op_a   = bypass(i_slot.ctrl.r1, i_slot.r1_data);
        rt_val = bypass(i_slot.ctrl.r2, i_slot.r2_data);
        op_b   = i_slot.ctrl.imm_sel ? i_slot.ctrl.imm : rt_val;

        o_slot         = i_slot;
        o_slot.r1_data = op_a;
        o_slot.r2_data = rt_val; // store data travels on
        case (i_slot.ctrl.alu_op)
            ALU_ADD:  o_slot.result = op_a + op_b; // also addi and ldr/str address
            ALU_SUB:  o_slot.result = op_a - op_b;
            ALU_AND:  o_slot.result = op_a & op_b;
            ALU_OR:   o_slot.result = op_a | op_b;
            ALU_XOR:  o_slot.result = op_a ^ op_b;
            ALU_PASS: o_slot.result = op_b;
            default:  o_slot.result = '0;
        endcase
    end

endmodule

/* src/lc4_fetch.sv */
`timescale 1ns/1ps

module lc4_fetch import lc4_pkg::*; (
    input  logic  gwe,
    input  logic  i_arst_n,
    input  logic  i_hold,
    input  logic  i_swap,
    input  insn_u i_insn_a,
    input  insn_u i_insn_b,
    output word_t o_pc,
    output slot_t o_d_slot_a,
    output slot_t o_d_slot_b
);

    word_t pc_q;
    word_t fetch_pc;
    slot_t nxt_a;
    slot_t nxt_b;

    // on a swap the younger decode insn is fetched again, now as pipe a
    assign fetch_pc = i_swap ? o_d_slot_b.pc : pc_q;
    assign o_pc     = fetch_pc;

    always_comb begin
        nxt_a       = '0;
        nxt_a.valid = 1'b1;
        nxt_a.pc    = fetch_pc;
        nxt_a.insn  = i_insn_a;
        nxt_b       = '0;
        nxt_b.valid = 1'b1;
        nxt_b.pc    = fetch_pc + 16'd1;
        nxt_b.insn  = i_insn_b;
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q       <= RESET_PC;
            o_d_slot_a <= '0; // insn 0 decodes as nop
            o_d_slot_b <= '0;
        end else if (!i_hold) begin
            pc_q       <= fetch_pc + 16'd2;
            o_d_slot_a <= nxt_a;
            o_d_slot_b <= nxt_b;
        end
    end

endmodule

/* src/lc4_hazard_unit.sv */
`timescale 1ns/1ps

module lc4_hazard_unit import lc4_pkg::*; (
    input  ctrl_t i_ctrl_a,
    input  ctrl_t i_ctrl_b,
    input  slot_t i_x_slot_a,
    input  slot_t i_x_slot_b,
    output logic  o_hold,
    output logic  o_swap,
    output logic  o_kill_a,
    output logic  o_kill_b
);

    logic load_use_a;
    logic load_use_b;
    logic pair_dep;

    // store rt is left out since the memory stage bypasses it
    function automatic logic reads_reg(input ctrl_t c, input reg_idx_t rd);
        return (c.r1_re && c.r1 == rd) || (c.r2_re && !c.is_store && c.r2 == rd);
    endfunction

    function automatic logic load_hit(input ctrl_t c, input slot_t x);
        return x.valid && x.ctrl.is_load && reads_reg(c, x.ctrl.rd);
    endfunction

    assign load_use_a = load_hit(i_ctrl_a, i_x_slot_a) || load_hit(i_ctrl_a, i_x_slot_b);
    assign load_use_b = load_hit(i_ctrl_b, i_x_slot_a) || load_hit(i_ctrl_b, i_x_slot_b);

    assign pair_dep = (i_ctrl_a.rf_we && reads_reg(i_ctrl_b, i_ctrl_a.rd))
                    || ((i_ctrl_a.is_load || i_ctrl_a.is_store)
                        && (i_ctrl_b.is_load || i_ctrl_b.is_store)); // one dmem port

    assign o_hold   = load_use_a;
    assign o_swap   = !load_use_a && (pair_dep || load_use_b);
    assign o_kill_a = load_use_a;
    assign o_kill_b = load_use_a || o_swap;

endmodule

/* src/lc4_mem_stage.sv */
`timescale 1ns/1ps

module lc4_mem_stage import lc4_pkg::*; (
    input  logic    gwe,
    input  logic    i_arst_n,
    input  slot_t   i_m_slot_a,
    input  slot_t   i_m_slot_b,
    input  word_t   i_dmem_rdata,
    output word_t   o_dmem_addr,
    output word_t   o_dmem_wdata,
    output logic    o_dmem_we,
    output fwd_t    o_w_a,
    output fwd_t    o_w_b,
    output retire_t o_retire_a,
    output retire_t o_retire_b
);

    logic  acc_a;
    logic  acc_b;
    logic  use_b;
    word_t st_data_a;
    word_t st_data_b;
    slot_t w_a;
    slot_t w_b;
    word_t w_addr_a;
    word_t w_addr_b;

    assign acc_a = i_m_slot_a.valid && (i_m_slot_a.ctrl.is_load || i_m_slot_a.ctrl.is_store);
    assign acc_b = i_m_slot_b.valid && (i_m_slot_b.ctrl.is_load || i_m_slot_b.ctrl.is_store);
    assign use_b = acc_b && !acc_a;

    function automatic word_t wm_bypass(input reg_idx_t idx, input word_t val);
        if (o_w_b.we && o_w_b.rd == idx) return o_w_b.value;
        if (o_w_a.we && o_w_a.rd == idx) return o_w_a.value;
        return val;
    endfunction

    always_comb begin
        st_data_a = wm_bypass(i_m_slot_a.ctrl.r2, i_m_slot_a.r2_data);
        st_data_b = wm_bypass(i_m_slot_b.ctrl.r2, i_m_slot_b.r2_data);
        // pair partner a is newer than anything in writeback
        if (i_m_slot_a.valid && i_m_slot_a.ctrl.rf_we
                && i_m_slot_a.ctrl.rd == i_m_slot_b.ctrl.r2) begin
            st_data_b = i_m_slot_a.result;
        end
    end

    assign o_dmem_addr  = use_b ? i_m_slot_b.result : i_m_slot_a.result;
    assign o_dmem_wdata = use_b ? st_data_b : st_data_a;
    assign o_dmem_we    = (acc_a && i_m_slot_a.ctrl.is_store) || (acc_b && i_m_slot_b.ctrl.is_store);

    function automatic slot_t to_wb(input slot_t m, input word_t st_data, input word_t rdata);
        slot_t w;
        w         = m;
        w.r2_data = st_data;
        if (m.ctrl.is_load) w.result = rdata;
        return w;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            w_a <= '0;
            w_b <= '0;
        end else begin
            w_a <= to_wb(i_m_slot_a, st_data_a, i_dmem_rdata);
            w_b <= to_wb(i_m_slot_b, st_data_b, i_dmem_rdata);
        end
    end

    always_ff @(posedge gwe) begin
        w_addr_a <= i_m_slot_a.result; // load result gets replaced by data
        w_addr_b <= i_m_slot_b.result;
    end

    assign o_w_a = '{we: w_a.valid && w_a.ctrl.rf_we, rd: w_a.ctrl.rd, value: w_a.result};
    assign o_w_b = '{we: w_b.valid && w_b.ctrl.rf_we, rd: w_b.ctrl.rd, value: w_b.result};

    function automatic retire_t to_retire(input slot_t w, input word_t addr);
        retire_t r;
        r.valid     = w.valid;
        r.pc        = w.pc;
        r.insn      = w.insn;
        r.rf_we     = w.ctrl.rf_we;
        r.wsel      = w.ctrl.rd;
        r.wdata     = w.result;
        r.dmem_we   = w.ctrl.is_store;
        r.dmem_addr = (w.ctrl.is_load || w.ctrl.is_store) ? addr : '0;
        r.dmem_data = w.ctrl.is_store ? w.r2_data : (w.ctrl.is_load ? w.result : '0);
        return r;
    endfunction

    assign o_retire_a = to_retire(w_a, w_addr_a);
    assign o_retire_b = to_retire(w_b, w_addr_b);

    // decode splits every pair with two memory ops
    a_one_port: assert property (@(posedge gwe) disable iff (!i_arst_n) !(acc_a && acc_b));

endmodule

/* src/lc4_pkg.sv */
package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;

    localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;

    // insn[15:12]
    localparam logic [3:0] OP_ARITH = 4'd1;
    localparam logic [3:0] OP_LOGIC = 4'd5;
    localparam logic [3:0] OP_LDR   = 4'd6;
    localparam logic [3:0] OP_STR   = 4'd7;
    localparam logic [3:0] OP_CONST = 4'd9;

    // insn[4:3] of the register forms, insn[5] clear
    localparam logic [1:0] SUB_ADD = 2'b00;
    localparam logic [1:0] SUB_SUB = 2'b10;
    localparam logic [1:0] SUB_AND = 2'b00;
    localparam logic [1:0] SUB_OR  = 2'b10;
    localparam logic [1:0] SUB_XOR = 2'b11;

    localparam logic [2:0] ALU_ADD  = 3'd0;
    localparam logic [2:0] ALU_SUB  = 3'd1;
    localparam logic [2:0] ALU_AND  = 3'd2;
    localparam logic [2:0] ALU_OR   = 3'd3;
    localparam logic [2:0] ALU_XOR  = 3'd4;
    localparam logic [2:0] ALU_PASS = 3'd5; // second operand straight through

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic       imm_flag;
        logic [1:0] sub_op;
        reg_idx_t   rt;
    } insn_reg_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   rd_rt; // rd for LDR, rt for STR
        reg_idx_t   rs;
        logic [5:0] offset6;
    } insn_off_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   rd;
        logic [8:0] imm9;
    } insn_cst_t;

    typedef union packed {
        insn_reg_t rv;
        insn_off_t ov;
        insn_cst_t cv;
    } insn_u;

    typedef struct packed {
        reg_idx_t   r1;
        logic       r1_re;
        reg_idx_t   r2;
        logic       r2_re;
        reg_idx_t   rd;
        logic       rf_we;
        logic       is_load;
        logic       is_store;
        logic [2:0] alu_op;
        word_t      imm;
        logic       imm_sel;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_u insn;
        ctrl_t ctrl;
        word_t r1_data;
        word_t r2_data;
        word_t result; // alu result, or load data from writeback on
    } slot_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_idx_t wsel;
        word_t    wdata;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } retire_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    value;
    } fwd_t;

endpackage

/* src/lc4_regfile.sv */
`timescale 1ns/1ps

module lc4_regfile import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_arst_n,
    input  reg_idx_t i_rs_a,
    input  reg_idx_t i_rt_a,
    input  reg_idx_t i_rs_b,
    input  reg_idx_t i_rt_b,
    input  fwd_t     i_wr_a,
    input  fwd_t     i_wr_b,
    output word_t    o_rs_data_a,
    output word_t    o_rt_data_a,
    output word_t    o_rs_data_b,
    output word_t    o_rt_data_b
);

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wr_a.we) regs[i_wr_a.rd] <= i_wr_a.value;
            if (i_wr_b.we) regs[i_wr_b.rd] <= i_wr_b.value; // younger, lands last
        end
    end

    // write-through, b checked first
    function automatic word_t read_port(input reg_idx_t idx);
        if (i_wr_b.we && i_wr_b.rd == idx) return i_wr_b.value;
        if (i_wr_a.we && i_wr_a.rd == idx) return i_wr_a.value;
        return regs[idx];
    endfunction

    always_comb begin
        o_rs_data_a = read_port(i_rs_a);
        o_rt_data_a = read_port(i_rt_a);
        o_rs_data_b = read_port(i_rs_b);
        o_rt_data_b = read_port(i_rt_b);
    end

endmodule
